/* src.f */
hw/rs_ctrl_pkg.sv
hw/symbol_counters.sv
hw/decode_sequencer.sv
hw/transfer_sequencer.sv
hw/rs_main_control.sv
testbench/rs_main_control_chk.sv
testbench/rs_main_control_tb.sv

/* Bender.yml */
package:
  name: rs_main_control

sources:
  - files:
      - hw/rs_ctrl_pkg.sv
      - hw/symbol_counters.sv
      - hw/decode_sequencer.sv
      - hw/transfer_sequencer.sv
      - hw/rs_main_control.sv
  - target: test
    files:
      - testbench/rs_main_control_chk.sv
      - testbench/rs_main_control_tb.sv

/* testbench/rs_main_control_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the RS decoder main controller. Runs directed tests for
// reset, clean, correctable, uncorrectable and overlapped codewords, and
// checks strobe timing every cycle while the tests drive the inputs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_main_control_tb;

   import rs_ctrl_pkg::*;

   localparam int len = default_codeword_len;
   localparam int wait_limit = 4 * len + 40;

   logic    clock1 = 1'b0;
   logic    reset;
   logic    start;
   logic    errdetect;
   logic    finish_kes;
   degree_t rootcntr;
   degree_t lambda_degree;
   logic    ready, active_sc, active_kes, active_csee, evalsynd, holdsynd;
   logic    errfound, decode_fail, dataoutstart, dataoutend, shift_fifo;
   logic    hold_fifo, en_infifo, en_outfifo, lastdataout, evalerror;

   integer seed;
   int     n_sc, n_synd, n_errfound, n_kes, n_csee, n_start, n_end, n_fail;
   int     n_rx_win, n_out_win, n_overlap, n_sc_in_out;
   int     rx_run = 0;
   int     out_run = 0;
   logic   in_decode = 1'b0;
   logic   prev_kes = 1'b0;
   logic   prev_end = 1'b0;
   logic   prev_rx = 1'b0;
   logic   prev_out = 1'b0;

   rs_main_control #(.codeword_len(len)) uut (.*);

   always #5 clock1 = ~clock1;

   task automatic check_value(input string what, input int actual, input int expected);
      if (actual != expected) begin
         $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic clear_tallies();
      n_sc = 0;
      n_synd = 0;
      n_errfound = 0;
      n_kes = 0;
      n_csee = 0;
      n_start = 0;
      n_end = 0;
      n_fail = 0;
      n_rx_win = 0;
      n_out_win = 0;
      n_overlap = 0;
      n_sc_in_out = 0;
   endtask

   // Advance to the next falling edge, then tally and check the outputs
   task automatic tick();
      @(negedge clock1);
      if (uut.u_chk.failures != 0) begin
         $display("a protocol assertion failed before %0t ns", $time);
         $display("Errors found");
         $fatal(1);
      end
      n_sc += active_sc;
      n_synd += evalsynd;
      n_errfound += errfound;
      n_csee += active_csee;
      n_start += dataoutstart;
      n_end += dataoutend;
      n_fail += decode_fail;
      if (active_sc && en_outfifo) n_sc_in_out++;
      if (en_infifo && evalerror) n_overlap++;
      if (active_kes && !prev_kes) n_kes++;
      if (!active_kes && prev_kes) check_value("dataoutend before active_kes falls", prev_end, 1);
      if (decode_fail) check_value("dataoutend before decode_fail", prev_end, 1);
      // Receive window ends with datainfinish, evalsynd follows
      if (!en_infifo && prev_rx) begin
         check_value("en_infifo window length", rx_run, len + 1);
         check_value("evalsynd after receive", evalsynd, 1);
         n_rx_win++;
      end
      if (!evalerror && prev_out) begin
         check_value("evalerror window length", out_run, len + 1);
         check_value("dataoutend after output", dataoutend, 1);
         n_out_win++;
      end
      rx_run = en_infifo ? rx_run + 1 : 0;
      out_run = evalerror ? out_run + 1 : 0;
      check_value("dataoutstart", dataoutstart, evalerror && (out_run == 2));
      // Last output symbol closes the evalerror window
      check_value("lastdataout", lastdataout, out_run == len + 1);
      if (en_infifo) check_value("shift_fifo while receiving", shift_fifo, 1);
      if (evalsynd) begin
         check_value("holdsynd with evalsynd", holdsynd, 1);
         check_value("hold_fifo with evalsynd", hold_fifo, 1);
      end
      if (en_outfifo) in_decode = 1'b0;
      if (evalsynd) in_decode = 1'b1;
      if (in_decode) check_value("ready during decode", ready, 0);
      prev_kes = active_kes;
      prev_end = dataoutend;
      prev_rx = en_infifo;
      prev_out = evalerror;
   endtask

   function automatic logic output_by_name(input string name);
      if (name == "en_outfifo") return en_outfifo;
      else if (name == "evalsynd") return evalsynd;
      else if (name == "dataoutend") return dataoutend;
      else return 1'b0;
   endfunction

   task automatic wait_for(input string name, input int limit);
      int cycles;
      cycles = 0;
      while (!output_by_name(name)) begin
         tick();
         cycles++;
         if (cycles > limit) begin
            $display("timeout at %0t ns: %s never went high", $time, name);
            $display("Errors found");
            $fatal(1);
         end
      end
   endtask

   // One-cycle start, load strobe next cycle, receive right after
   task automatic pulse_start();
      start = 1'b1;
      tick();
      start = 1'b0;
      check_value("active_sc after start", active_sc, 1);
      tick();
      check_value("active_sc second cycle", active_sc, 0);
      check_value("en_infifo after active_sc", en_infifo, 1);
   endtask

   task automatic decode_frame(input logic err, input degree_t lam, input degree_t roots,
                               input int kes_delay);
      errdetect = err;
      lambda_degree = lam;
      rootcntr = roots;
      pulse_start();
      wait_for("evalsynd", wait_limit);
      tick();
      if (err) begin
         check_value("errfound", errfound, 1);
         check_value("active_kes with errfound", active_kes, 1);
         repeat (kes_delay) begin
            tick();
            check_value("active_kes while solving", active_kes, 1);
            check_value("active_csee while solving", active_csee, 0);
            check_value("en_outfifo while solving", en_outfifo, 0);
         end
         finish_kes = 1'b1;
         tick();
         finish_kes = 1'b0;
         check_value("active_csee after finish_kes", active_csee, 1);
         check_value("en_outfifo with active_csee", en_outfifo, 0);
         tick();
         check_value("active_csee pulse end", active_csee, 0);
         check_value("en_outfifo after search start", en_outfifo, 1);
      end else begin
         check_value("en_outfifo after evalsynd", en_outfifo, 1);
         check_value("errfound on clean frame", errfound, 0);
      end
      wait_for("dataoutend", wait_limit);
      tick();
      check_value("decode_fail", decode_fail, err && (lam != roots));
      check_value("ready after output", ready, 1);
      tick();
      check_value("decode_fail pulse end", decode_fail, 0);
   endtask

   task automatic test_reset();
      tick();
      check_value("outputs after reset",
                  {ready, active_sc, active_kes, active_csee, evalsynd, holdsynd,
                   errfound, decode_fail, dataoutstart, dataoutend, shift_fifo,
                   hold_fifo, en_infifo, en_outfifo, lastdataout, evalerror}, 32'h8000);
   endtask

   task automatic test_clean();
      clear_tallies();
      decode_frame(1'b0, 3'd0, 3'd0, 0);
      check_value("clean active_sc count", n_sc, 1);
      check_value("clean evalsynd count", n_synd, 1);
      check_value("clean active_kes rises", n_kes, 0);
      check_value("clean receive windows", n_rx_win, 1);
      check_value("clean output windows", n_out_win, 1);
      check_value("clean dataoutstart count", n_start, 1);
      check_value("clean dataoutend count", n_end, 1);
      check_value("clean decode_fail count", n_fail, 0);
   endtask

   task automatic test_correctable();
      degree_t deg;
      int      delay;
      deg = degree_t'($random(seed));
      delay = 1 + ($unsigned($random(seed)) % 8);
      clear_tallies();
      decode_frame(1'b1, deg, deg, delay);
      check_value("correctable errfound count", n_errfound, 1);
      check_value("correctable active_csee count", n_csee, 1);
      check_value("correctable decode_fail count", n_fail, 0);
      check_value("correctable output windows", n_out_win, 1);
   endtask

   task automatic test_uncorrectable();
      degree_t deg;
      degree_t roots;
      deg = degree_t'($random(seed));
      roots = deg + degree_t'(1 + ($unsigned($random(seed)) % 7));
      clear_tallies();
      decode_frame(1'b1, deg, roots, 2);
      check_value("uncorrectable decode_fail count", n_fail, 1);
      check_value("uncorrectable dataoutend count", n_end, 1);
   endtask

   // Second start lands while the first frame is being output
   task automatic test_overlap();
      clear_tallies();
      errdetect = 1'b0;
      pulse_start();
      wait_for("en_outfifo", wait_limit);
      pulse_start();
      wait_for("dataoutend", wait_limit);
      tick();
      wait_for("dataoutend", wait_limit);
      tick();
      check_value("overlap active_sc count", n_sc, 2);
      check_value("active_sc during output", n_sc_in_out, 1);
      check_value("receive during output", n_overlap > 0, 1);
      check_value("overlap receive windows", n_rx_win, 2);
      check_value("overlap output windows", n_out_win, 2);
      check_value("overlap dataoutend count", n_end, 2);
      check_value("overlap decode_fail count", n_fail, 0);
      check_value("ready after overlap", ready, 1);
   endtask

   initial begin
      seed = 32'h2d2fa27a;
      reset = 1'b0;
      start = 1'b0;
      errdetect = 1'b0;
      finish_kes = 1'b0;
      rootcntr = '0;
      lambda_degree = '0;
      clear_tallies();
      repeat (3) @(negedge clock1);
      reset = 1'b1;
      test_reset();
      test_clean();
      test_correctable();
      test_uncorrectable();
      test_overlap();
      if (uut.u_chk.failures == 0) begin
         $display("No errors");
         $finish;
      end else begin
         $display("Errors found");
         $fatal(1);
      end
   end

endmodule

/* testbench/rs_main_control_chk.sv */
////////////////////////////////////////////////////////////////////////////
// Protocol assertions on the control strobes of the RS main controller.
// Bound into the top level, failures are raised with $error.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_main_control_chk (
   input logic clock1,
   input logic reset,
   input logic active_sc,
   input logic active_csee,
   input logic dataoutstart,
   input logic dataoutend,
   input logic decode_fail,
   input logic evalsynd,
   input logic en_outfifo
);

   // Number of failed assertions, read by the testbench
   int unsigned failures = 0;

   a_sc_single: assert property (@(posedge clock1) disable iff (!reset)
      active_sc |=> !active_sc)
      else begin
         failures++;
         $error("active_sc high for more than one cycle");
      end

   a_csee_single: assert property (@(posedge clock1) disable iff (!reset)
      active_csee |=> !active_csee)
      else begin
         failures++;
         $error("active_csee high for more than one cycle");
      end

   a_frame_strobes: assert property (@(posedge clock1) disable iff (!reset)
      !(dataoutstart && dataoutend))
      else begin
         failures++;
         $error("dataoutstart and dataoutend high together");
      end

   // Failure is flagged only right after output ends
   a_fail_after_end: assert property (@(posedge clock1) disable iff (!reset)
      decode_fail |-> $past(dataoutend))
      else begin
         failures++;
         $error("decode_fail without dataoutend in the previous cycle");
      end

   a_synd_not_out: assert property (@(posedge clock1) disable iff (!reset)
      !(evalsynd && en_outfifo))
      else begin
         failures++;
         $error("evalsynd and en_outfifo high together");
      end

endmodule

bind rs_main_control rs_main_control_chk u_chk (
   .clock1(clock1),
   .reset(reset),
   .active_sc(active_sc),
   .active_csee(active_csee),
   .dataoutstart(dataoutstart),
   .dataoutend(dataoutend),
   .decode_fail(decode_fail),
   .evalsynd(evalsynd),
   .en_outfifo(en_outfifo)
);

/* hw/rs_main_control.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the RS decoder main controller. Connects the decode
// sequencer, the transfer sequencer and the symbol counters. All control
// strobes are single-cycle or level signals on clock1.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_main_control #(
   parameter int codeword_len = rs_ctrl_pkg::default_codeword_len
) (
   input  logic                 clock1,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 errdetect,
   input  logic                 finish_kes,
   input  rs_ctrl_pkg::degree_t rootcntr,
   input  rs_ctrl_pkg::degree_t lambda_degree,
   output logic                 ready,
   output logic                 active_sc,
   output logic                 active_kes,
   output logic                 active_csee,
   output logic                 evalsynd,
   output logic                 holdsynd,
   output logic                 errfound,
   output logic                 decode_fail,
   output logic                 dataoutstart,
   output logic                 dataoutend,
   output logic                 shift_fifo,
   output logic                 hold_fifo,
   output logic                 en_infifo,
   output logic                 en_outfifo,
   output logic                 lastdataout,
   output logic                 evalerror
);

   logic datainfinish;
   logic count_in_en;
   logic rx_last;

   decode_sequencer u_decode (
      .clock1(clock1), .reset(reset), .start(start),
      .errdetect(errdetect), .finish_kes(finish_kes),
      .rootcntr(rootcntr), .lambda_degree(lambda_degree),
      .datainfinish(datainfinish), .dataoutend(dataoutend),
      .ready(ready), .active_sc(active_sc), .active_kes(active_kes),
      .active_csee(active_csee), .evalsynd(evalsynd), .errfound(errfound),
      .decode_fail(decode_fail), .en_outfifo(en_outfifo)
   );

   transfer_sequencer #(.codeword_len(codeword_len)) u_transfer (
      .clock1(clock1), .reset(reset), .active_sc(active_sc),
      .en_outfifo(en_outfifo), .rx_last(rx_last), .lastdataout(lastdataout),
      .shift_fifo(shift_fifo), .hold_fifo(hold_fifo), .en_infifo(en_infifo),
      .holdsynd(holdsynd), .dataoutstart(dataoutstart),
      .dataoutend(dataoutend), .datainfinish(datainfinish),
      .count_in_en(count_in_en), .evalerror(evalerror)
   );

   symbol_counters #(.codeword_len(codeword_len)) u_counters (
      .clock1(clock1), .reset(reset), .count_in_en(count_in_en),
      .evalerror(evalerror), .rx_last(rx_last), .lastdataout(lastdataout)
   );

endmodule

/* hw/transfer_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Transfer sequencer of the RS main controller. Moore FSM that fills the
// input FIFO, holds it during syndrome evaluation and shifts the codeword
// out to the corrector. The overlap states receive the next codeword while
// the current one is still being output.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transfer_sequencer #(
   parameter int codeword_len = rs_ctrl_pkg::default_codeword_len
) (
   input  logic clock1,
   input  logic reset,
   input  logic active_sc,
   input  logic en_outfifo,
   input  logic rx_last,
   input  logic lastdataout,
   output logic shift_fifo,
   output logic hold_fifo,
   output logic en_infifo,
   output logic holdsynd,
   output logic dataoutstart,
   output logic dataoutend,
   output logic datainfinish,
   output logic count_in_en,
   output logic evalerror
);

   import rs_ctrl_pkg::*;

   transfer_state_t state;
   transfer_state_t state_next;

   // The overlap needs the input count to trail the output count
   if (codeword_len < 2) begin : g_len_check
      $fatal(1, "codeword_len must be at least 2");
   end

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset)
         state <= xfr_idle;
      else
         state <= state_next;
   end

   always_comb begin
      state_next = state;
      case (state)
         xfr_idle:
            if (active_sc) state_next = xfr_rx;
         xfr_rx:
            if (rx_last) state_next = xfr_rx_done;
         xfr_rx_done:
            state_next = xfr_hold;
         xfr_hold:
            if (en_outfifo) state_next = xfr_out_first;
         xfr_out_first:
            state_next = active_sc ? xfr_overlap_start : xfr_out_start;
         xfr_out_start:
            state_next = active_sc ? xfr_overlap_run : xfr_out_run;
         xfr_out_run: begin
            // Last symbol out together with a load strobe starts receiving at once
            if (lastdataout)
               state_next = active_sc ? xfr_overlap_done : xfr_out_done;
            else if (active_sc)
               state_next = xfr_overlap_run;
         end
         xfr_out_done:
            state_next = active_sc ? xfr_rx : xfr_idle;
         xfr_overlap_start:
            state_next = xfr_overlap_run;
         xfr_overlap_run: begin
            if (lastdataout && rx_last)
               state_next = xfr_overlap_done_rx;
            else if (lastdataout)
               state_next = xfr_overlap_done;
         end
         xfr_overlap_done_rx:
            state_next = xfr_hold;
         // Output finished, the new frame keeps receiving
         xfr_overlap_done:
            state_next = rx_last ? xfr_rx_done : xfr_rx;
         default:
            state_next = xfr_idle;
      endcase
   end

   // Moore outputs, evalerror also enables the output counter
   always_comb begin
      shift_fifo   = 1'b0;
      hold_fifo    = 1'b0;
      en_infifo    = 1'b0;
      holdsynd     = 1'b0;
      dataoutstart = 1'b0;
      dataoutend   = 1'b0;
      datainfinish = 1'b0;
      count_in_en  = 1'b0;
      evalerror    = 1'b0;
      case (state)
         xfr_rx, xfr_overlap_run, xfr_overlap_done: begin
            shift_fifo  = 1'b1;
            en_infifo   = 1'b1;
            count_in_en = 1'b1;
            evalerror   = (state == xfr_overlap_run);
            dataoutend  = (state == xfr_overlap_done);
         end
         xfr_rx_done: begin
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            datainfinish = 1'b1;
         end
         xfr_hold: begin
            hold_fifo = 1'b1;
            holdsynd  = 1'b1;
         end
         xfr_out_first: begin
            hold_fifo = 1'b1;
            evalerror = 1'b1;
         end
         xfr_out_start: begin
            dataoutstart = 1'b1;
            shift_fifo   = 1'b1;
            evalerror    = 1'b1;
         end
         xfr_out_run: begin
            shift_fifo = 1'b1;
            evalerror  = 1'b1;
         end
         xfr_out_done:
            dataoutend = 1'b1;
         xfr_overlap_start: begin
            dataoutstart = 1'b1;
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            count_in_en  = 1'b1;
            evalerror    = 1'b1;
         end
         xfr_overlap_done_rx: begin
            dataoutend   = 1'b1;
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            datainfinish = 1'b1;
         end
         default: begin
            shift_fifo = 1'b0;
         end
      endcase
   end

endmodule

/* hw/decode_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Decode sequencer of the RS main controller. Moore FSM that loads a new
// codeword, starts syndrome evaluation, runs the key-equation solver and
// the Chien search when errors are present, then releases the output FIFO.
// A start seen during output loads the next frame in the background.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_sequencer (
   input  logic                 clock1,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 errdetect,
   input  logic                 finish_kes,
   input  rs_ctrl_pkg::degree_t rootcntr,
   input  rs_ctrl_pkg::degree_t lambda_degree,
   input  logic                 datainfinish,
   input  logic                 dataoutend,
   output logic                 ready,
   output logic                 active_sc,
   output logic                 active_kes,
   output logic                 active_csee,
   output logic                 evalsynd,
   output logic                 errfound,
   output logic                 decode_fail,
   output logic                 en_outfifo
);

   import rs_ctrl_pkg::*;

   decode_state_t state;
   decode_state_t state_next;
   logic          degree_match;
   logic          rx_pending;

   // Decoding succeeded when every locator root was found
   assign degree_match = (lambda_degree == rootcntr);

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state      <= dec_idle;
         rx_pending <= 1'b0;
      end else begin
         state      <= state_next;
         // Next frame finished receiving in the same cycle as a failed output
         rx_pending <= datainfinish && (state_next == dec_fail_rx);
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         dec_idle:
            if (start) state_next = dec_load;
         dec_load:
            state_next = dec_wait_rx;
         dec_wait_rx:
            if (datainfinish) state_next = dec_eval_synd;
         dec_eval_synd:
            state_next = errdetect ? dec_err_found : dec_clean_out;
         dec_err_found:
            state_next = dec_kes_run;
         dec_kes_run:
            if (finish_kes) state_next = dec_csee_start;
         dec_csee_start:
            state_next = dec_out_wait;
         dec_out_wait: begin
            if (dataoutend)
               state_next = degree_match ? dec_idle : dec_fail_idle;
            else if (start)
               state_next = dec_out_load;
         end
         // Output of the corrected frame with the next frame loading
         dec_out_load, dec_out_busy: begin
            if (dataoutend) begin
               if (!degree_match)
                  state_next = dec_fail_rx;
               else if (datainfinish)
                  state_next = dec_eval_synd;
               else
                  state_next = dec_wait_rx;
            end else begin
               state_next = dec_out_busy;
            end
         end
         dec_fail_idle:
            state_next = start ? dec_load : dec_idle;
         dec_fail_rx:
            state_next = (datainfinish || rx_pending) ? dec_eval_synd : dec_wait_rx;
         dec_clean_out: begin
            if (dataoutend)
               state_next = dec_idle;
            else if (start)
               state_next = dec_clean_load;
         end
         dec_clean_load, dec_clean_busy: begin
            if (dataoutend)
               state_next = datainfinish ? dec_eval_synd : dec_wait_rx;
            else
               state_next = dec_clean_busy;
         end
         default:
            state_next = dec_idle;
      endcase
   end

   // Moore outputs
   always_comb begin
      ready       = 1'b1;
      active_sc   = 1'b0;
      active_kes  = 1'b0;
      active_csee = 1'b0;
      evalsynd    = 1'b0;
      errfound    = 1'b0;
      decode_fail = 1'b0;
      en_outfifo  = 1'b0;
      case (state)
         dec_load:
            active_sc = 1'b1;
         dec_eval_synd: begin
            ready    = 1'b0;
            evalsynd = 1'b1;
         end
         dec_err_found: begin
            ready      = 1'b0;
            active_kes = 1'b1;
            errfound   = 1'b1;
         end
         dec_kes_run: begin
            ready      = 1'b0;
            active_kes = 1'b1;
         end
         dec_csee_start: begin
            ready       = 1'b0;
            active_kes  = 1'b1;
            active_csee = 1'b1;
         end
         dec_out_wait, dec_out_busy: begin
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         dec_out_load: begin
            active_sc  = 1'b1;
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         dec_fail_idle, dec_fail_rx:
            decode_fail = 1'b1;
         dec_clean_out, dec_clean_busy:
            en_outfifo = 1'b1;
         dec_clean_load: begin
            active_sc  = 1'b1;
            en_outfifo = 1'b1;
         end
         default: begin
            ready = 1'b1;
         end
      endcase
   end

endmodule

/* hw/symbol_counters.sv */
////////////////////////////////////////////////////////////////////////////
// Input and output symbol counters of the RS main controller. Each counter
// runs while its enable is high and clears as soon as it drops. Only the
// end-of-receive and end-of-output flags leave this block.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module symbol_counters #(
   parameter int codeword_len = rs_ctrl_pkg::default_codeword_len
) (
   input  logic clock1,
   input  logic reset,
   input  logic count_in_en,
   input  logic evalerror,
   output logic rx_last,
   output logic lastdataout
);

   // Output count has to reach codeword_len itself
   localparam int cnt_w = $clog2(codeword_len + 1);

   logic [cnt_w-1:0] in_cnt;
   logic [cnt_w-1:0] out_cnt;

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         in_cnt  <= '0;
         out_cnt <= '0;
      end else begin
         in_cnt  <= count_in_en ? in_cnt + 1'b1 : '0;
         out_cnt <= evalerror ? out_cnt + 1'b1 : '0;
      end
   end

   assign rx_last     = (in_cnt == cnt_w'(codeword_len - 1));
   assign lastdataout = (out_cnt == cnt_w'(codeword_len));

endmodule

/* hw/rs_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the Reed-Solomon decoder main controller.
// Holds the state encodings of both sequencers, the error-locator degree
// type and the default number of symbols per codeword.
////////////////////////////////////////////////////////////////////////////

package rs_ctrl_pkg;

   // Symbols per codeword for RS(31,k) over GF(2^5)
   localparam int default_codeword_len = 31;

   // Error-locator degree or number of Chien search roots
   typedef logic [2:0] degree_t;

   typedef enum logic [3:0] {
      dec_idle, dec_load, dec_wait_rx, dec_eval_synd,
      dec_err_found, dec_kes_run, dec_csee_start,
      dec_out_wait, dec_out_load, dec_out_busy,
      dec_fail_idle, dec_fail_rx,
      dec_clean_out, dec_clean_load, dec_clean_busy
   } decode_state_t;

   typedef enum logic [3:0] {
      xfr_idle, xfr_rx, xfr_rx_done, xfr_hold,
      xfr_out_first, xfr_out_start, xfr_out_run, xfr_out_done,
      xfr_overlap_start, xfr_overlap_run,
      xfr_overlap_done_rx, xfr_overlap_done
   } transfer_state_t;

endpackage
